// ==== dv/pipelineControlTb.sv ====
// ------------------------------------------------------------
// testbench for pipelineControl, lfsr and directed stimulus,
// reference pipeline model and checking assertions
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pipeSettings_settings.svh"

module pipelineControlTb;
	import pipePkg::*;

	localparam logic [15:0] lfsrSeed = 16'd10246;
	localparam logic [3:0] codeLoad = 4'b0000;
	localparam logic [3:0] codeStore = 4'b0010;
	localparam logic [3:0] codeAdd = 4'b0100;
	localparam logic [3:0] codeOri = 4'b0111;
	localparam logic [3:0] codeShift = 4'b0011;
	localparam logic [3:0] codeBz = 4'b0101;
	localparam logic [3:0] codeBnz = 4'b1001;
	localparam logic [3:0] codeBpz = 4'b1101;
	localparam logic [3:0] codeStop = 4'b0001;

	logic clock;
	logic reset;
	instrT fetchedInstr;
	logic flagN;
	logic flagZ;
	execCtrlT execCtrl;
	wbCtrlT wbCtrl;
	bypassT bypass;
	logic pcSel;
	logic halted;

	instrT modelIr1; // reference copy of the pipeline
	instrT modelIr2;
	instrT modelIr3;
	logic modelHalted;
	execCtrlT expExec;
	wbCtrlT expWb;
	bypassT expBypass;
	logic expPcSel;
	logic [15:0] lfsr;
	int errorCount;
	int timeoutCount;

	pipelineControl DUT
	(
		.clock(clock),
		.reset(reset),
		.fetchedInstr(fetchedInstr),
		.flagN(flagN),
		.flagZ(flagZ),
		.execCtrl(execCtrl),
		.wbCtrl(wbCtrl),
		.bypass(bypass),
		.pcSel(pcSel),
		.halted(halted)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	// ------------------------------------------------------------
	// expected values from the opcode and control tables
	// ------------------------------------------------------------
	function automatic opClassT classOf(instrT i);
		opClassT c;
		case (i.op)
			4'b0000: c = opLoad;
			4'b0010: c = opStore;
			4'b0100: c = opAdd;
			4'b0110: c = opSub;
			4'b1000: c = opNand;
			4'b0101: c = opBz;
			4'b1001: c = opBnz;
			4'b1101: c = opBpz;
			4'b0001: c = opStop;
			4'b1010: c = opNop;
			default: c = (i.op[2:0] == 3'b111) ? opOri : (i.op[2:0] == 3'b011) ? opShift : opIllegal;
		endcase
		return c;
	endfunction

	function automatic execCtrlT expectedExec(instrT i, logic halt);
		execCtrlT e;
		opClassT c;
		e = '0;
		c = classOf(i);
		if (!halt)
		begin
			case (c)
				opLoad:
				begin
					e.memRead = 1'b1;
					e.mdrLoad = 1'b1;
				end
				opStore: e.memWrite = 1'b1;
				opAdd:
				begin
					e.flagWrite = 1'b1;
					e.aluIn2Sel = aluIn2Reg;
					e.aluOp = aluAdd;
				end
				opSub:
				begin
					e.flagWrite = 1'b1;
					e.aluIn2Sel = aluIn2Reg;
					e.aluOp = aluSub;
				end
				opNand:
				begin
					e.flagWrite = 1'b1;
					e.aluIn2Sel = aluIn2Reg;
					e.aluOp = aluNand;
				end
				opShift:
				begin
					e.flagWrite = 1'b1;
					e.aluIn2Sel = aluIn2Shamt;
					e.aluOp = aluShift;
				end
				opOri:
				begin
					e.flagWrite = 1'b1;
					e.aluIn2Sel = aluIn2Imm;
					e.aluOp = aluOri;
				end
				opBz, opBnz, opBpz:
				begin
					e.aluIn1Sel = aluIn1Pc; // target is pc plus offset
					e.aluIn2Sel = aluIn2Offset;
					e.aluOp = aluAdd;
				end
				default: ; // nop, stop, illegal
			endcase
		end
		return e;
	endfunction

	function automatic wbCtrlT expectedWb(instrT i);
		wbCtrlT w;
		opClassT c;
		c = classOf(i);
		w.rfWrite = c inside {opAdd, opSub, opNand, opOri, opShift, opLoad};
		w.regIn = (c == opLoad); // mdr path
		w.rwSel = (c == opOri); // fixed r1
		return w;
	endfunction

	function automatic bypassT expectedBypass(instrT cons, instrT prod);
		bypassT b;
		opClassT pc;
		logic [`REG_SEL_WIDTH-1:0] dest;
		b = '0;
		pc = classOf(prod);
		dest = (pc == opOri) ? `REG_SEL_WIDTH'(`ORI_DEST_REG) : prod.regA;
		if (pc inside {opAdd, opSub, opNand, opShift, opOri})
		begin
			case (classOf(cons))
				opAdd, opSub, opNand:
				begin
					b.aluIn1 = (cons.regA == dest);
					b.aluIn2 = (cons.regB == dest);
				end
				opShift: b.aluIn1 = (cons.regA == dest);
				opOri: b.aluIn1 = (dest == `REG_SEL_WIDTH'(`ORI_DEST_REG));
				opStore:
				begin
					b.memData = (cons.regA == dest);
					b.memAddress = (cons.regB == dest);
				end
				opLoad: b.memAddress = (cons.regB == dest);
				default: ;
			endcase
		end
		return b;
	endfunction

	function automatic logic expectedTaken(instrT i, logic n, logic z, logic halt);
		logic cond;
		case (classOf(i))
			opBz: cond = z;
			opBnz: cond = !z;
			opBpz: cond = !n;
			default: cond = 1'b0;
		endcase
		return cond && ({i.regA, i.regB} != 4'd0) && !halt;
	endfunction

	function automatic logic haltRequest(instrT i);
		opClassT c;
		c = classOf(i);
		return (c == opStop) || ((c inside {opBz, opBnz, opBpz}) && {i.regA, i.regB} == 4'd0);
	endfunction

	// ------------------------------------------------------------
	// reference pipeline model
	// ------------------------------------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			modelIr1 <= nopInstr;
			modelIr2 <= nopInstr;
			modelIr3 <= nopInstr;
			modelHalted <= 1'b0;
		end
		else
		begin
			modelIr3 <= modelIr2;
			modelIr1 <= pcSel ? nopInstr : fetchedInstr; // squash on the dut's pcSel
			modelIr2 <= pcSel ? nopInstr : modelIr1;
			if (haltRequest(modelIr2))
				modelHalted <= 1'b1;
		end
	end

	always_comb
	begin
		expExec = expectedExec(modelIr2, modelHalted);
		expWb = expectedWb(modelIr3);
		expBypass = expectedBypass(modelIr2, modelIr3);
		expPcSel = expectedTaken(modelIr2, flagN, flagZ, modelHalted);
	end

	function automatic void reportMismatch(string sigName, logic [31:0] got, logic [31:0] want);
		errorCount++;
		$display("[ERROR] %0t ns %s got %h expected %h", $time, sigName, got, want);
	endfunction

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	assert property (@(posedge clock) execCtrl == expExec)
		else reportMismatch("execCtrl", 32'($sampled(execCtrl)), 32'($sampled(expExec)));
	assert property (@(posedge clock) wbCtrl == expWb)
		else reportMismatch("wbCtrl", 32'($sampled(wbCtrl)), 32'($sampled(expWb)));
	assert property (@(posedge clock) bypass == expBypass)
		else reportMismatch("bypass", 32'($sampled(bypass)), 32'($sampled(expBypass)));
	assert property (@(posedge clock) pcSel == expPcSel)
		else reportMismatch("pcSel", 32'($sampled(pcSel)), 32'($sampled(expPcSel)));
	assert property (@(posedge clock) halted == modelHalted)
		else reportMismatch("halted", 32'($sampled(halted)), 32'($sampled(modelHalted)));
	assert property (@(posedge clock) reset |-> {execCtrl, wbCtrl, bypass, pcSel, halted} == '0)
		else reportMismatch("outputs in reset",
			32'($sampled({execCtrl, wbCtrl, bypass, pcSel, halted})), 32'd0);
	// two bubbles behind a taken branch
	assert property (@(posedge clock) !reset && ($past(pcSel) || $past(pcSel, 2)) |-> execCtrl == '0)
		else reportMismatch("execCtrl after squash", 32'($sampled(execCtrl)), 32'd0);
	assert property (@(posedge clock) !reset && ($past(pcSel, 2) || $past(pcSel, 3)) |-> wbCtrl == '0)
		else reportMismatch("wbCtrl after squash", 32'($sampled(wbCtrl)), 32'd0);
	assert property (@(posedge clock) halted |-> execCtrl == '0 && !pcSel)
		else reportMismatch("execCtrl,pcSel while halted", 32'($sampled({execCtrl, pcSel})), 32'd0);

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	function automatic logic nextBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16 14 13 11
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic instrT randomInstr();
		logic [`INSTR_WIDTH-1:0] v;
		v = '0;
		for (int k = 0; k < `INSTR_WIDTH; k++)
			v = {v[`INSTR_WIDTH-2:0], nextBit()};
		return instrT'(v);
	endfunction

	function automatic instrT makeInstr(logic [1:0] a, logic [1:0] b, logic [3:0] op);
		return '{regA: a, regB: b, op: op};
	endfunction

	task automatic sendInstr(instrT instr, logic n, logic z);
		@(negedge clock);
		fetchedInstr = instr;
		flagN = n;
		flagZ = z;
	endtask

	task automatic sendRandom();
		sendInstr(randomInstr(), nextBit(), nextBit());
	endtask

	task automatic resetDut(int cycles);
		@(negedge clock);
		reset = 1'b1;
		fetchedInstr = nopInstr;
		repeat (cycles) @(negedge clock);
		reset = 1'b0;
	endtask

	task automatic waitHalted(int limit);
		int waited;
		waited = 0;
		while (!halted && waited < limit)
		begin
			sendRandom(); // anything behind the halting instruction
			waited++;
		end
		if (!halted)
		begin
			timeoutCount++;
			$display("timeout: halted did not rise within %0d cycles", limit);
		end
	endtask

	task automatic branchCase(instrT br, logic n, logic z, logic taken);
		int waited;
		sendInstr(br, n, z);
		waited = 0;
		while (taken && !pcSel && waited < 4)
		begin
			sendInstr(makeInstr(2'd3, 2'd3, codeAdd), n, z); // follower, flags held
			waited++;
		end
		if (taken && !pcSel)
		begin
			timeoutCount++;
			$display("timeout: taken branch never raised pcSel");
		end
		repeat (3) sendInstr(makeInstr(2'd3, 2'd3, codeAdd), n, z);
	endtask

	task automatic forwardPair(instrT producer, instrT consumer);
		sendInstr(producer, 1'b0, 1'b0);
		sendInstr(consumer, 1'b0, 1'b0); // back to back
	endtask

	initial
	begin
		int heldCycles;
		reset = 1'b1;
		fetchedInstr = nopInstr;
		flagN = 1'b0;
		flagZ = 1'b0;
		lfsr = lfsrSeed;
		errorCount = 0;
		timeoutCount = 0;
		heldCycles = 0;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		// writeback table
		sendInstr(makeInstr(2'd1, 2'd2, codeAdd), 1'b0, 1'b0);
		sendInstr(makeInstr(2'd2, 2'd1, codeOri), 1'b0, 1'b0);
		sendInstr(makeInstr(2'd2, 2'd3, codeLoad), 1'b0, 1'b0);
		sendInstr(makeInstr(2'd0, 2'd1, codeStore), 1'b0, 1'b0);
		repeat (3) sendInstr(nopInstr, 1'b0, 1'b0);

		// forwarding, match then no match per consumer class
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd2, 2'd2, codeAdd));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd0, 2'd3, codeAdd));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd2, 2'd0, codeShift));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd1, 2'd0, codeShift));
		forwardPair(makeInstr(2'd3, 2'd0, codeOri), makeInstr(2'd0, 2'd2, codeOri));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd0, 2'd2, codeOri));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd2, 2'd2, codeStore));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd0, 2'd1, codeStore));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd0, 2'd2, codeLoad));
		forwardPair(makeInstr(2'd2, 2'd1, codeAdd), makeInstr(2'd0, 2'd3, codeLoad));

		// branches, offset 6
		branchCase(makeInstr(2'd1, 2'd2, codeBz), 1'b0, 1'b1, 1'b1);
		branchCase(makeInstr(2'd1, 2'd2, codeBnz), 1'b1, 1'b0, 1'b1);
		branchCase(makeInstr(2'd1, 2'd2, codeBpz), 1'b0, 1'b1, 1'b1);
		branchCase(makeInstr(2'd1, 2'd2, codeBz), 1'b1, 1'b0, 1'b0); // not taken

		// halt by stop, then by zero offset branch
		sendInstr(makeInstr(2'd0, 2'd0, codeStop), 1'b0, 1'b0);
		waitHalted(6);
		repeat (12) sendRandom();
		resetDut(2);
		sendInstr(makeInstr(2'd0, 2'd0, codeBnz), 1'b0, 1'b0);
		waitHalted(6);
		repeat (12) sendRandom();
		resetDut(2);

		// random stream, re-reset once a halt has held a while
		for (int cycle = 0; cycle < 1500; cycle++)
		begin
			sendRandom();
			heldCycles = halted ? heldCycles + 1 : 0;
			if (heldCycles >= 8)
			begin
				resetDut(2);
				heldCycles = 0;
			end
		end
		repeat (4) sendInstr(nopInstr, 1'b0, 1'b0);

		$display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/pipePkg.sv
verilog/forwardUnit.sv
verilog/executeDecode.sv
verilog/writebackDecode.sv
verilog/pipelineControl.sv
dv/pipelineControlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	-f flist.f \
	--top-module pipelineControlTb \
	--Mdir obj_dir \
	-o simPipeline

./obj_dir/simPipeline | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== verilog/executeDecode.sv ====
// ------------------------------------------------------------
// execute stage controls, branch resolution, sticky halt
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pipeSettings_settings.svh"

module executeDecode
(
	input logic clock,
	input logic reset,
	input pipePkg::instrT ir2,
	input logic flagN,
	input logic flagZ,
	output pipePkg::execCtrlT execCtrl,
	output logic pcSel, // branch taken, also squashes ir1 and ir2
	output logic halted
);
	import pipePkg::*;

	opClassT opClass;
	logic [`INSTR_WIDTH-`OPCODE_WIDTH-1:0] offset; // regA and regB joined
	logic isBranch;
	logic condMet; // flag test for this branch kind
	logic haltReq;
	execCtrlT ctrl; // ungated decode

	assign opClass = decodeOp(ir2);
	assign offset = {ir2.regA, ir2.regB};
	assign isBranch = opClass inside {opBz, opBnz, opBpz};

	// zero offset branch is a self loop, treated like stop
	assign haltReq = (opClass == opStop) || (isBranch && offset == '0);

	// ------------------------------------------------------------
	// halt register
	// ------------------------------------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			halted <= 1'b0;
		else if (haltReq)
			halted <= 1'b1; // held until reset
	end

	// ------------------------------------------------------------
	// control decode
	// ------------------------------------------------------------
	always_comb
	begin
		ctrl = '0; // illegal, nop, stop fall through here
		case (opClass)
			opLoad:
			begin
				ctrl.memRead = 1'b1;
				ctrl.mdrLoad = 1'b1; // capture read data
			end
			opStore: ctrl.memWrite = 1'b1;
			opAdd, opSub, opNand:
			begin
				ctrl.flagWrite = 1'b1;
				ctrl.aluIn2Sel = aluIn2Reg;
				ctrl.aluOp = (opClass == opAdd) ? aluAdd :
					(opClass == opSub) ? aluSub : aluNand;
			end
			opShift:
			begin
				ctrl.flagWrite = 1'b1;
				ctrl.aluIn2Sel = aluIn2Shamt;
				ctrl.aluOp = aluShift;
			end
			opOri:
			begin
				ctrl.flagWrite = 1'b1;
				ctrl.aluIn2Sel = aluIn2Imm;
				ctrl.aluOp = aluOri;
			end
			opBz, opBnz, opBpz:
			begin
				ctrl.aluIn1Sel = aluIn1Pc; // pc + offset, flags untouched
				ctrl.aluIn2Sel = aluIn2Offset;
				ctrl.aluOp = aluAdd;
			end
			default: ;
		endcase
	end

	always_comb
	begin
		case (opClass)
			opBz: condMet = flagZ;
			opBnz: condMet = !flagZ;
			opBpz: condMet = !flagN; // positive or zero
			default: condMet = 1'b0;
		endcase
	end

	// nothing issues once halted
	assign execCtrl = halted ? '0 : ctrl;
	assign pcSel = condMet && (offset != '0) && !halted;

	// memory port is single ported
	assert property (@(posedge clock) disable iff (reset)
		!(execCtrl.memRead && execCtrl.memWrite))
		else $error("memRead and memWrite both high");

endmodule

`default_nettype wire

// ==== verilog/forwardUnit.sv ====
// ------------------------------------------------------------
// forwarding selects for alu inputs and data memory ports
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pipeSettings_settings.svh"

module forwardUnit
(
	input pipePkg::instrT ir2, // consumer, execute stage
	input pipePkg::instrT ir3, // producer, writeback stage
	output pipePkg::bypassT bypass
);
	import pipePkg::*;

	opClassT cls2;
	opClassT cls3;
	logic producer; // ir3 writes an alu result this cycle
	logic [`REG_SEL_WIDTH-1:0] dest; // register ir3 writes

	assign cls2 = decodeOp(ir2);
	assign cls3 = decodeOp(ir3);

	// loads are not forwarded, data arrives too late
	assign producer = cls3 inside {opAdd, opSub, opNand, opShift, opOri};
	assign dest = (cls3 == opOri) ? `REG_SEL_WIDTH'(`ORI_DEST_REG) : ir3.regA;

	always_comb
	begin
		bypass = '0;
		if (producer)
		begin
			case (cls2)
				opAdd, opSub, opNand:
				begin
					bypass.aluIn1 = (ir2.regA == dest);
					bypass.aluIn2 = (ir2.regB == dest);
				end
				opShift: bypass.aluIn1 = (ir2.regA == dest); // shifts regA in place
				opOri: bypass.aluIn1 = (dest == `REG_SEL_WIDTH'(`ORI_DEST_REG)); // reads r1
				opStore:
				begin
					bypass.memData = (ir2.regA == dest); // value to store
					bypass.memAddress = (ir2.regB == dest);
				end
				opLoad: bypass.memAddress = (ir2.regB == dest);
				default: ; // branches, nop, stop read nothing forwardable
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pipePkg.sv ====
// ------------------------------------------------------------
// opcode class and alu select enums, control structs,
// nop constant and the shared instruction decode function
// ------------------------------------------------------------
`default_nettype none

`include "pipeSettings_settings.svh"

package pipePkg;

	// ------------------------------------------------------------
	// instruction word
	// ------------------------------------------------------------
	typedef struct packed {
		logic [`REG_SEL_WIDTH-1:0] regA; // bits 7:6, dest or offset high
		logic [`REG_SEL_WIDTH-1:0] regB; // bits 5:4, source or offset low
		logic [`OPCODE_WIDTH-1:0] op; // bits 3:0
	} instrT;

	// decoded instruction kinds
	typedef enum logic [3:0] {
		opLoad,
		opStore,
		opAdd,
		opSub,
		opNand,
		opOri,
		opShift,
		opBz,
		opBnz,
		opBpz,
		opStop,
		opNop,
		opIllegal // anything not in the table
	} opClassT;

	// alu operation codes as the datapath expects them
	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluOri = 3'b010,
		aluNand = 3'b011,
		aluShift = 3'b100
	} aluOpT;

	typedef enum logic {
		aluIn1Reg = 1'b0, // register file port
		aluIn1Pc = 1'b1 // branch target base
	} aluIn1SelT;

	typedef enum logic [2:0] {
		aluIn2Reg = 3'd0, // register file port
		aluIn2Offset = 3'd2, // sign-extended branch offset
		aluIn2Imm = 3'd3, // ori immediate
		aluIn2Shamt = 3'd4 // shift amount field
	} aluIn2SelT;

	// ------------------------------------------------------------
	// control bundles
	// ------------------------------------------------------------
	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic mdrLoad;
		logic flagWrite; // update n and z
		aluIn1SelT aluIn1Sel;
		aluIn2SelT aluIn2Sel;
		aluOpT aluOp;
	} execCtrlT;

	typedef struct packed {
		logic rfWrite; // register file write enable
		logic regIn; // 1 picks mdr, 0 picks alu out
		logic rwSel; // 1 forces write reg to r1
	} wbCtrlT;

	typedef struct packed {
		logic aluIn1; // take wb result on alu input 1
		logic aluIn2;
		logic memData; // store data from wb result
		logic memAddress;
	} bypassT;

	// bubble used at reset and on squash
	localparam instrT nopInstr = '{regA: '0, regB: '0, op: 4'b1010};

	// opcode to class, full nibble first then 3-bit forms
	function automatic opClassT decodeOp(input instrT instr);
		opClassT cls;
		case (instr.op)
			4'b0000: cls = opLoad;
			4'b0010: cls = opStore;
			4'b0100: cls = opAdd;
			4'b0110: cls = opSub;
			4'b1000: cls = opNand;
			4'b0101: cls = opBz;
			4'b1001: cls = opBnz;
			4'b1101: cls = opBpz;
			4'b0001: cls = opStop;
			4'b1010: cls = opNop;
			default:
			begin
				case (instr.op[2:0])
					3'b111: cls = opOri; // immediate in upper bits
					3'b011: cls = opShift;
					default: cls = opIllegal;
				endcase
			end
		endcase
		return cls;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/pipeSettings_settings.svh ====
// ------------------------------------------------------------
// width and field macros for the pipeline control unit
// ------------------------------------------------------------
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// instruction word layout
`define INSTR_WIDTH 8 // full instruction byte
`define OPCODE_WIDTH 4 // low nibble, op field
`define REG_SEL_WIDTH 2 // regA and regB fields

// ori writes a fixed register
`define ORI_DEST_REG 1 // r1 is the ori destination

`endif

// ==== verilog/pipelineControl.sv ====
// ------------------------------------------------------------
// pipeline control top, instruction registers ir1..ir3,
// branch squash and the three stage decoders
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pipelineControl
(
	input logic clock,
	input logic reset,
	input pipePkg::instrT fetchedInstr,
	input logic flagN,
	input logic flagZ,
	output pipePkg::execCtrlT execCtrl,
	output pipePkg::wbCtrlT wbCtrl,
	output pipePkg::bypassT bypass,
	output logic pcSel,
	output logic halted
);
	import pipePkg::*;

	instrT ir1; // register read
	instrT ir2; // execute
	instrT ir3; // writeback

	// ------------------------------------------------------------
	// instruction registers
	// ------------------------------------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			ir1 <= nopInstr;
			ir2 <= nopInstr;
			ir3 <= nopInstr;
		end
		else
		begin
			ir3 <= ir2; // branch itself still retires
			if (pcSel)
			begin
				ir1 <= nopInstr; // kill both younger slots
				ir2 <= nopInstr;
			end
			else
			begin
				ir1 <= fetchedInstr;
				ir2 <= ir1;
			end
		end
	end

	// ------------------------------------------------------------
	// stage decoders
	// ------------------------------------------------------------
	executeDecode uExecute
	(
		.clock(clock),
		.reset(reset),
		.ir2(ir2),
		.flagN(flagN),
		.flagZ(flagZ),
		.execCtrl(execCtrl),
		.pcSel(pcSel),
		.halted(halted)
	);

	writebackDecode uWriteback
	(
		.ir3(ir3),
		.wbCtrl(wbCtrl)
	);

	forwardUnit uForward
	(
		.ir2(ir2),
		.ir3(ir3),
		.bypass(bypass)
	);

	// taken branch leaves bubbles behind it
	assert property (@(posedge clock) disable iff (reset)
		pcSel |=> (ir1 == nopInstr) && (ir2 == nopInstr))
		else $error("squash did not clear ir1 and ir2");

endmodule

`default_nettype wire

// ==== verilog/writebackDecode.sv ====
// ------------------------------------------------------------
// writeback stage controls decoded from ir3
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module writebackDecode
(
	input pipePkg::instrT ir3,
	output pipePkg::wbCtrlT wbCtrl
);
	import pipePkg::*;

	opClassT opClass;

	assign opClass = decodeOp(ir3);

	always_comb
	begin
		wbCtrl = '0; // store, branches, nop, stop write nothing
		case (opClass)
			opAdd, opSub, opNand, opShift: wbCtrl.rfWrite = 1'b1; // alu result to regA
			opOri:
			begin
				wbCtrl.rfWrite = 1'b1;
				wbCtrl.rwSel = 1'b1; // dest forced to r1
			end
			opLoad:
			begin
				wbCtrl.rfWrite = 1'b1;
				wbCtrl.regIn = 1'b1; // take mdr
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire
